//--- Bender.yml
package:
  name: mac_unit

sources:
  - common/mac_pkg.sv
  - hdl/operand_select.sv
  - mac/mac_pipeline.sv
  - hdl/result_buffer.sv
  - hdl/mac_unit_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/mac_unit_assertions.sv
      - tests/mac_unit_tb.sv

//--- common/mac_pkg.sv
`default_nettype none

package mac_pkg;

   // flow bus geometry
   localparam int N_LANES = 4;
   localparam int LANE_W = 2;

   // configuration field widths
   localparam int PERIOD_W = 4;
   localparam int SHIFT_W = 5;

   // static configuration word, 17 bits
   typedef struct packed {
      logic [LANE_W-1:0]   sel_a;
      logic [LANE_W-1:0]   sel_b;
      logic [LANE_W-1:0]   sel_c;
      // beats per group, 0 stands for 16
      logic [PERIOD_W-1:0] period;
      logic [SHIFT_W-1:0]  shift;
      logic                acc_in;
      logic                acc_out;
   } mac_cfg_t;

   // group position tags that ride with every beat
   typedef struct packed {
      logic first;
      logic last;
   } mac_tag_t;

   // width of the tagged operand word between the input side and the pipeline
   function automatic int op_w(input int data_w);
      return 3 * data_w + $bits(mac_tag_t);
   endfunction

   // width of the accumulator and of the sum handed to the output side
   function automatic int sum_w(input int data_w);
      return 2 * data_w;
   endfunction

   // index of the last beat in a group
   // period 0 wraps to 15, which gives 16 beats
   function automatic logic [PERIOD_W-1:0] last_beat(input logic [PERIOD_W-1:0] period);
      return period - 1'b1;
   endfunction

endpackage

`default_nettype wire

//--- hdl/mac_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module mac_unit_top #(
   parameter int DATA_W = 16
) (
   input  logic                                   clk,
   input  logic                                   rst,
   input  mac_pkg::mac_cfg_t                      cfg,
   input  logic [mac_pkg::N_LANES*DATA_W-1:0]     in_lanes,
   input  logic                                   in_valid,
   output logic                                   in_ready,
   output logic [DATA_W-1:0]                      out_data,
   output logic                                   out_valid,
   input  logic                                   out_ready
);

   logic [mac_pkg::op_w(DATA_W)-1:0]  op;
   logic                              op_valid;
   logic [mac_pkg::sum_w(DATA_W)-1:0] sum;
   logic                              sum_valid;
   // global stall enable from the output side
   logic                              adv;

   operand_select #(
      .DATA_W(DATA_W)
   ) u_operand_select (
      .clk(clk),
      .rst(rst),
      .cfg(cfg),
      .in_lanes(in_lanes),
      .in_valid(in_valid),
      .in_ready(in_ready),
      .adv(adv),
      .op(op),
      .op_valid(op_valid)
   );

   mac_pipeline #(
      .DATA_W(DATA_W)
   ) u_mac_pipeline (
      .clk(clk),
      .rst(rst),
      .cfg(cfg),
      .op(op),
      .op_valid(op_valid),
      .adv(adv),
      .sum(sum),
      .sum_valid(sum_valid)
   );

   result_buffer #(
      .DATA_W(DATA_W)
   ) u_result_buffer (
      .clk(clk),
      .rst(rst),
      .cfg(cfg),
      .sum(sum),
      .sum_valid(sum_valid),
      .adv(adv),
      .out_data(out_data),
      .out_valid(out_valid),
      .out_ready(out_ready)
   );

endmodule

`default_nettype wire

//--- hdl/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select #(
   parameter int DATA_W = 16
) (
   input  logic                                   clk,
   input  logic                                   rst,
   input  mac_pkg::mac_cfg_t                      cfg,
   input  logic [mac_pkg::N_LANES*DATA_W-1:0]     in_lanes,
   input  logic                                   in_valid,
   output logic                                   in_ready,
   input  logic                                   adv,
   output logic [mac_pkg::op_w(DATA_W)-1:0]       op,
   output logic                                   op_valid
);

   typedef struct packed {
      logic signed [DATA_W-1:0] a;
      logic signed [DATA_W-1:0] b;
      logic signed [DATA_W-1:0] c;
      mac_pkg::mac_tag_t        tag;
   } op_t;

   logic [DATA_W-1:0]            lanes [mac_pkg::N_LANES];
   logic [mac_pkg::PERIOD_W-1:0] beat_cnt;
   logic                         accept;
   logic                         is_first;
   logic                         is_last;
   op_t                          op_q;

   // split the flow bus into lanes
   always_comb begin
      for (int i = 0; i < mac_pkg::N_LANES; i++) begin
         lanes[i] = in_lanes[i*DATA_W +: DATA_W];
      end
   end

   // the whole unit stalls together, so ready is just the advance enable
   assign in_ready = adv;
   assign accept = in_valid && adv;

   assign is_first = (beat_cnt == '0);
   assign is_last = (beat_cnt == mac_pkg::last_beat(cfg.period));

   // position within the current group
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         beat_cnt <= '0;
      end else if (accept) begin
         if (is_last) begin
            beat_cnt <= '0;
         end else begin
            beat_cnt <= beat_cnt + 1'b1;
         end
      end
   end

   // valid bit follows the input whenever the stage moves
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         op_valid <= 1'b0;
      end else if (adv) begin
         op_valid <= in_valid;
      end
   end

   // operand payload
   always_ff @(posedge clk) begin
      if (accept) begin
         op_q.a <= lanes[cfg.sel_a];
         op_q.b <= lanes[cfg.sel_b];
         op_q.c <= lanes[cfg.sel_c];
         op_q.tag.first <= is_first;
         op_q.tag.last <= is_last;
      end
   end

   assign op = op_q;

endmodule

`default_nettype wire

//--- hdl/result_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module result_buffer #(
   parameter int DATA_W = 16
) (
   input  logic                                   clk,
   input  logic                                   rst,
   input  mac_pkg::mac_cfg_t                      cfg,
   input  logic [mac_pkg::sum_w(DATA_W)-1:0]      sum,
   input  logic                                   sum_valid,
   output logic                                   adv,
   output logic [DATA_W-1:0]                      out_data,
   output logic                                   out_valid,
   input  logic                                   out_ready
);

   localparam int SUM_W = mac_pkg::sum_w(DATA_W);

   logic signed [SUM_W-1:0] shifted;
   logic [DATA_W-1:0]       result;
   logic [DATA_W-1:0]       mem [2];
   logic                    wr_ptr;
   logic                    rd_ptr;
   logic [1:0]              count;
   logic                    push;
   logic                    pop;

   // arithmetic shift, then pick a half
   assign shifted = $signed(sum) >>> cfg.shift;
   assign result = cfg.acc_out ? shifted[SUM_W-1:DATA_W] : shifted[DATA_W-1:0];

   assign pop = out_valid && out_ready;
   // room left once this cycle's pop is taken into account
   assign adv = (count < 2'd2) || pop;
   assign push = sum_valid && adv;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         count <= '0;
      end else begin
         if (push) begin
            wr_ptr <= ~wr_ptr;
         end
         if (pop) begin
            rd_ptr <= ~rd_ptr;
         end
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

   // storage
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= result;
      end
   end

   assign out_valid = (count != '0);
   assign out_data = mem[rd_ptr];

endmodule

`default_nettype wire

//--- mac/mac_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module mac_pipeline #(
   parameter int DATA_W = 16
) (
   input  logic                                   clk,
   input  logic                                   rst,
   input  mac_pkg::mac_cfg_t                      cfg,
   input  logic [mac_pkg::op_w(DATA_W)-1:0]       op,
   input  logic                                   op_valid,
   input  logic                                   adv,
   output logic [mac_pkg::sum_w(DATA_W)-1:0]      sum,
   output logic                                   sum_valid
);

   localparam int SUM_W = mac_pkg::sum_w(DATA_W);

   typedef struct packed {
      logic signed [DATA_W-1:0] a;
      logic signed [DATA_W-1:0] b;
      logic signed [DATA_W-1:0] c;
      mac_pkg::mac_tag_t        tag;
   } op_t;

   // product stage contents
   typedef struct packed {
      logic signed [SUM_W-1:0] prod;
      logic signed [SUM_W-1:0] bias;
      mac_pkg::mac_tag_t       tag;
   } prod_t;

   op_t                     op_s;
   logic signed [SUM_W-1:0] prod_d;
   logic signed [SUM_W-1:0] bias_d;
   prod_t                   prod_q;
   logic                    prod_valid;
   logic signed [SUM_W-1:0] acc_q;
   logic                    acc_valid;
   logic                    acc_last;

   assign op_s = op;

   // full double-width signed product
   assign prod_d = op_s.a * op_s.b;

   // bias from c, sign-extended, only when enabled
   always_comb begin
      if (cfg.acc_in) begin
         bias_d = {{DATA_W{op_s.c[DATA_W-1]}}, op_s.c};
      end else begin
         bias_d = '0;
      end
   end

   // stage one control
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         prod_valid <= 1'b0;
      end else if (adv) begin
         prod_valid <= op_valid;
      end
   end

   // stage one payload
   always_ff @(posedge clk) begin
      if (adv && op_valid) begin
         prod_q.prod <= prod_d;
         prod_q.bias <= bias_d;
         prod_q.tag <= op_s.tag;
      end
   end

   // stage two control
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         acc_valid <= 1'b0;
         acc_last <= 1'b0;
      end else if (adv) begin
         acc_valid <= prod_valid;
         acc_last <= prod_q.tag.last;
      end
   end

   // accumulator, reloaded at the start of every group
   always_ff @(posedge clk) begin
      if (adv && prod_valid) begin
         if (prod_q.tag.first) begin
            acc_q <= prod_q.bias + prod_q.prod;
         end else begin
            acc_q <= acc_q + prod_q.prod;
         end
      end
   end

   // one result per group
   assign sum = acc_q;
   assign sum_valid = acc_valid && acc_last;

endmodule

`default_nettype wire

//--- tb.f
common/mac_pkg.sv
hdl/operand_select.sv
mac/mac_pipeline.sv
hdl/result_buffer.sv
hdl/mac_unit_top.sv
tests/tb_clock.sv
tests/mac_unit_assertions.sv
tests/mac_unit_tb.sv

//--- tests/mac_unit_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module mac_unit_assertions #(
   parameter int DATA_W = 16
) (
   input logic              clk,
   input logic              rst,
   input logic              in_ready,
   input logic [DATA_W-1:0] out_data,
   input logic              out_valid,
   input logic              out_ready
);

   int fail_count = 0;

   // a stalled result must not change under the consumer
   hold_data: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> $stable(out_data))
   else begin
      fail_count++;
      $error("out_data changed while out_valid was high and out_ready low");
   end

   reset_quiet: assert property (@(posedge clk) rst |-> !out_valid)
   else begin
      fail_count++;
      $error("out_valid high during reset");
   end

   // with the consumer ready the unit must not stall for long
   no_lockup: assert property (@(posedge clk) disable iff (rst)
      (!in_ready && out_ready) [*64] |=> (in_ready || !out_ready))
   else begin
      fail_count++;
      $error("in_ready low for more than 64 cycles with out_ready high");
   end

endmodule

`default_nettype wire

//--- tests/mac_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mac_unit_tb;

   localparam int DATA_W = 16;
   localparam int N_LANES = mac_pkg::N_LANES;
   // beats over all tests, sets the watchdog
   localparam int TOTAL_BEATS = 40 * 1 + 12 * 5 + 6 * 16 + 6 * 16 + 30 * 3;

   logic                      clk;
   logic                      rst;
   mac_pkg::mac_cfg_t         cfg;
   logic [N_LANES*DATA_W-1:0] in_lanes;
   logic                      in_valid;
   logic                      in_ready;
   logic [DATA_W-1:0]         out_data;
   logic                      out_valid;
   logic                      out_ready;

   integer                     seed;
   logic [DATA_W-1:0]          expected_q [$];
   logic signed [2*DATA_W-1:0] acc_m;
   int                         beat_pos;
   logic                       pending;
   int                         target_beats;
   int                         valid_pct;
   int                         ready_pct;
   logic                       small_data;
   int                         accepted;
   int                         results;
   int                         test_errors;
   int                         n_tests;
   int                         n_checks;
   int                         n_errors;
   string                      test_name;
   logic [mac_pkg::SHIFT_W-1:0] shift_lo;
   logic [mac_pkg::SHIFT_W-1:0] shift_hi;

   tb_clock #(.PERIOD(4)) u_clock (.clk(clk));

   mac_unit_top #(
      .DATA_W(DATA_W)
   ) dut (
      .clk(clk),
      .rst(rst),
      .cfg(cfg),
      .in_lanes(in_lanes),
      .in_valid(in_valid),
      .in_ready(in_ready),
      .out_data(out_data),
      .out_valid(out_valid),
      .out_ready(out_ready)
   );

   bind mac_unit_top mac_unit_assertions #(
      .DATA_W(DATA_W)
   ) u_assertions (
      .clk(clk),
      .rst(rst),
      .in_ready(in_ready),
      .out_data(out_data),
      .out_valid(out_valid),
      .out_ready(out_ready)
   );

   function automatic logic chance(input int pct);
      return ($unsigned($random(seed)) % 100) < pct;
   endfunction

   function automatic logic [N_LANES*DATA_W-1:0] random_lanes(input logic small_vals);
      logic [N_LANES*DATA_W-1:0] v;
      integer r;
      for (int i = 0; i < N_LANES; i++) begin
         r = $random(seed);
         if (small_vals) begin
            r = r % 128;
         end
         v[i*DATA_W +: DATA_W] = r[DATA_W-1:0];
      end
      return v;
   endfunction

   function automatic mac_pkg::mac_cfg_t make_cfg(input int sel_a, input int sel_b,
                                                  input int sel_c, input int period,
                                                  input int shift, input logic acc_in,
                                                  input logic acc_out);
      mac_pkg::mac_cfg_t c;
      c.sel_a = sel_a[mac_pkg::LANE_W-1:0];
      c.sel_b = sel_b[mac_pkg::LANE_W-1:0];
      c.sel_c = sel_c[mac_pkg::LANE_W-1:0];
      c.period = period[mac_pkg::PERIOD_W-1:0];
      c.shift = shift[mac_pkg::SHIFT_W-1:0];
      c.acc_in = acc_in;
      c.acc_out = acc_out;
      return c;
   endfunction

   // reference model, one accepted beat
   task automatic model_beat();
      logic signed [DATA_W-1:0]   a;
      logic signed [DATA_W-1:0]   b;
      logic signed [DATA_W-1:0]   c;
      logic signed [2*DATA_W-1:0] shifted;
      int                         group_len;
      a = in_lanes[cfg.sel_a*DATA_W +: DATA_W];
      b = in_lanes[cfg.sel_b*DATA_W +: DATA_W];
      c = in_lanes[cfg.sel_c*DATA_W +: DATA_W];
      group_len = (cfg.period == 0) ? 16 : cfg.period;
      if (beat_pos == 0) begin
         if (cfg.acc_in) begin
            acc_m = c;
         end else begin
            acc_m = '0;
         end
      end
      acc_m = acc_m + a * b;
      if (beat_pos == group_len - 1) begin
         shifted = acc_m >>> cfg.shift;
         if (cfg.acc_out) begin
            expected_q.push_back(shifted[2*DATA_W-1:DATA_W]);
         end else begin
            expected_q.push_back(shifted[DATA_W-1:0]);
         end
         beat_pos = 0;
      end else begin
         beat_pos++;
      end
   endtask

   task automatic check_result();
      logic [DATA_W-1:0] exp;
      n_checks++;
      results++;
      assert (expected_q.size() > 0) else begin
         $display("%s: a result came out when none was expected", test_name);
         test_errors++;
      end
      if (expected_q.size() > 0) begin
         exp = expected_q.pop_front();
         assert (out_data == exp) else begin
            $display("error %s expected %h actual %h", test_name, exp, out_data);
            test_errors++;
         end
      end
   endtask

   // drive on the falling edge, sample 1 ns later while everything is settled
   task automatic step();
      @(negedge clk);
      if (!pending) begin
         if (accepted < target_beats && chance(valid_pct)) begin
            in_lanes = random_lanes(small_data);
            in_valid = 1'b1;
            pending = 1'b1;
         end else begin
            in_valid = 1'b0;
         end
      end
      out_ready = chance(ready_pct);
      #1;
      if (in_valid && in_ready) begin
         model_beat();
         accepted++;
         pending = 1'b0;
      end
      if (out_valid && out_ready) begin
         check_result();
      end
   endtask

   task automatic apply_reset(input mac_pkg::mac_cfg_t c);
      @(negedge clk);
      rst = 1'b1;
      in_valid = 1'b0;
      out_ready = 1'b0;
      cfg = c;
      expected_q.delete();
      repeat (10) @(negedge clk);
      rst = 1'b0;
   endtask

   task automatic run_test(input string name, input mac_pkg::mac_cfg_t c, input int n_groups,
                           input int v_pct, input int r_pct, input logic small_vals);
      int group_len;
      test_name = name;
      group_len = (c.period == 0) ? 16 : c.period;
      apply_reset(c);
      target_beats = n_groups * group_len;
      valid_pct = v_pct;
      ready_pct = r_pct;
      small_data = small_vals;
      accepted = 0;
      results = 0;
      test_errors = 0;
      beat_pos = 0;
      pending = 1'b0;
      while (accepted < target_beats) begin
         step();
      end
      // drain, then watch a few idle cycles for stray results
      ready_pct = 100;
      while (results < n_groups) begin
         step();
      end
      repeat (8) step();
      n_checks++;
      assert (expected_q.size() == 0 && results == accepted / group_len) else begin
         $display("%s: %0d results for %0d beats, %0d results still expected",
                  name, results, accepted, expected_q.size());
         test_errors++;
      end
      n_tests++;
      n_errors += test_errors;
      $display("test %s: %0d beats, %0d results, %s", name, accepted, results,
               (test_errors == 0) ? "ok" : "failed");
   endtask

   initial begin
      seed = 34379;
      rst = 1'b0;
      cfg = '0;
      in_lanes = '0;
      in_valid = 1'b0;
      out_ready = 1'b0;
      pending = 1'b0;
      n_tests = 0;
      n_checks = 0;
      n_errors = 0;
      run_test("single_beat", make_cfg(0, 1, 2, 1, 0, 1'b0, 1'b0), 40, 100, 100, 1'b1);
      run_test("bias_groups", make_cfg(3, 1, 0, 5, 0, 1'b1, 1'b0), 12, 100, 100, 1'b1);
      shift_lo = $random(seed);
      shift_hi = $random(seed);
      run_test("shift_lower", make_cfg(2, 3, 1, 0, shift_lo, 1'b0, 1'b0), 6, 100, 100, 1'b0);
      run_test("shift_upper", make_cfg(1, 2, 3, 0, shift_hi, 1'b1, 1'b1), 6, 100, 100, 1'b0);
      run_test("back_pressure", make_cfg(0, 3, 2, 3, 6, 1'b1, 1'b0), 30, 60, 50, 1'b0);
      $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
               n_tests, n_checks, n_errors, dut.u_assertions.fail_count);
      if (n_errors == 0 && dut.u_assertions.fail_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   // watchdog, generous margin per beat for resets and drains
   initial begin
      repeat (TOTAL_BEATS * 20) @(posedge clk);
      $display("timeout: the run did not finish within %0d cycles", TOTAL_BEATS * 20);
      $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
   parameter int PERIOD = 4
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   // free running, first rising edge half a period in
   always begin
      #(PERIOD / 2) clk = ~clk;
   end

endmodule

`default_nettype wire
